/* verilog/core_mem_port_defs.svh */
//////////////////////////////////////////////////////////////////////
// Widths and sizes shared by the memory-port RTL and its testbench.
// The data memory must stay a power of two in bytes.
//////////////////////////////////////////////////////////////////////

`ifndef CORE_MEM_PORT_DEFS_SVH
`define CORE_MEM_PORT_DEFS_SVH

// DMA side, top address bit selects instruction memory
`define CMP_DATA_WIDTH       64
`define CMP_STRB_WIDTH       8
`define CMP_ADDR_WIDTH       16

// Data memory
`define CMP_DMEM_SIZE_BYTES  32768
`define CMP_DMEM_ADDR_WIDTH  15

// Core messages (strobe, address, data)
`define CMP_MSG_DATA_WIDTH   32
`define CMP_MSG_STRB_WIDTH   4
`define CMP_MSG_WIDTH        51

// Top bits of a control word that mark a reset command
`define CMP_CTRL_TAG_WIDTH   16

`endif

/* verilog/core_mem_port_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Command, message and memory-port types. Widths come from the defs
// header, so it must be on the include path.
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "core_mem_port_defs.svh"

package core_mem_port_pkg;

  // Write and read are bitwise inverses, ~op gives the other one
  typedef enum logic [1:0] {
    DMEM_IDLE  = 2'b00,
    DMEM_WRITE = 2'b01,
    DMEM_READ  = 2'b10
  } dmem_op_e;

  typedef struct packed {
    logic                       en;
    logic [`CMP_ADDR_WIDTH-1:0] addr;
    logic [`CMP_DATA_WIDTH-1:0] data;
    logic [`CMP_STRB_WIDTH-1:0] strb;
    logic                       last;
  } wr_cmd_t;

  typedef struct packed {
    logic                       en;
    logic [`CMP_ADDR_WIDTH-1:0] addr;
    logic                       last;
  } rd_cmd_t;

  typedef struct packed {
    logic [`CMP_MSG_STRB_WIDTH-1:0]  strb;
    logic [`CMP_DMEM_ADDR_WIDTH-1:0] addr;
    logic [`CMP_MSG_DATA_WIDTH-1:0]  data;
  } core_msg_t;

  typedef struct packed {
    logic                       en;
    logic                       ren;
    logic [`CMP_STRB_WIDTH-1:0] wen;
    logic [`CMP_ADDR_WIDTH-1:0] addr;
    logic [`CMP_DATA_WIDTH-1:0] wdata;
  } dmem_req_t;

  // Instruction memory side is write only
  typedef struct packed {
    logic [`CMP_STRB_WIDTH-1:0] wen;
    logic [`CMP_ADDR_WIDTH-1:0] addr;
    logic [`CMP_DATA_WIDTH-1:0] data;
  } imem_wr_t;

endpackage

`default_nettype wire

/* verilog/port_control.sv */
//////////////////////////////////////////////////////////////////////
// Data memory arbiter, read response tracking and core reset register.
// Reads to the instruction memory range are never granted.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "core_mem_port_defs.svh"

module port_control #(
  parameter int interleave = 1
) (
  input  wire                             clk,
  input  wire                             rst,
  input  wire [`CMP_DATA_WIDTH-1:0]       ctrl_data,
  input  wire                             ctrl_valid,
  input  wire core_mem_port_pkg::wr_cmd_t wr_cmd,
  input  wire core_mem_port_pkg::rd_cmd_t rd_cmd,
  input  wire                             msg_active,
  input  wire                             rd_resp_ready,
  output logic                            wr_ready,
  output logic                            rd_ready,
  output logic                            rd_resp_valid,
  output core_mem_port_pkg::dmem_op_e     dmem_op,
  output logic                            imem_sel,
  output logic                            core_reset
);

  import core_mem_port_pkg::*;

  logic     reset_cmd;
  logic     read_reject;
  logic     dmem_wr_en;
  logic     dmem_rd_en;
  dmem_op_e dmem_last_op;
  logic     dmem_switch;
  logic     read_accepted_r;
  logic     read_rejected;

  //////////////////////////////////////////////////////////////////////
  // Core reset command

  // Tagged word: all top address-width bits set, bit 0 is the level
  assign reset_cmd = ctrl_valid &&
                     (&ctrl_data[`CMP_DATA_WIDTH-1 -: `CMP_CTRL_TAG_WIDTH]);

  always_ff @(posedge clk) begin
    if (rst) begin
      core_reset <= 1'b1;
    end else if (reset_cmd) begin
      core_reset <= ctrl_data[0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Split and arbitrate

  // A stalled response blocks new data memory reads
  assign read_reject = rd_resp_valid && !rd_resp_ready;

  assign imem_sel   = wr_cmd.en && wr_cmd.addr[`CMP_ADDR_WIDTH-1];
  assign dmem_wr_en = wr_cmd.en && !wr_cmd.addr[`CMP_ADDR_WIDTH-1];
  assign dmem_rd_en = rd_cmd.en && !rd_cmd.addr[`CMP_ADDR_WIDTH-1] && !read_reject;

  // Message owns the port outright, otherwise reads and writes take turns
  always_comb begin
    if (msg_active) begin
      dmem_op = DMEM_IDLE;
    end else begin
      case ({dmem_wr_en, dmem_rd_en})
        2'b01:   dmem_op = DMEM_READ;
        2'b10:   dmem_op = DMEM_WRITE;
        2'b11: begin
          // Coming out of idle both are pending, write goes first
          if (dmem_last_op == DMEM_IDLE) begin
            dmem_op = DMEM_WRITE;
          end else if ((interleave != 0) || dmem_switch) begin
            dmem_op = dmem_op_e'(~dmem_last_op);
          end else begin
            dmem_op = dmem_last_op;
          end
        end
        default: dmem_op = DMEM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dmem_last_op    <= DMEM_IDLE;
      dmem_switch     <= 1'b0;
      read_accepted_r <= 1'b0;
      read_rejected   <= 1'b0;
    end else begin
      dmem_last_op    <= dmem_op;
      // End of a burst lets the other side in when not interleaving
      dmem_switch     <= ((dmem_op == DMEM_READ) && rd_cmd.last) ||
                         ((dmem_op == DMEM_WRITE) && wr_cmd.last);
      read_accepted_r <= rd_ready;
      read_rejected   <= read_reject;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Handshakes

  // RAM data shows one cycle after the grant and holds while stalled
  assign rd_resp_valid = read_accepted_r || read_rejected;

  assign rd_ready = (dmem_op == DMEM_READ);

  // Instruction memory writes never wait
  assign wr_ready = !(dmem_wr_en && (dmem_op != DMEM_WRITE));

endmodule

`default_nettype wire

/* verilog/core_msg_stage.sv */
//////////////////////////////////////////////////////////////////////
// One-stage message register. No back-pressure, every valid is taken.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "core_mem_port_defs.svh"

module core_msg_stage (
  input  wire                               clk,
  input  wire                               rst,
  input  wire core_mem_port_pkg::core_msg_t msg_in,
  input  wire                               msg_valid,
  output logic                              msg_active,
  output logic [`CMP_DMEM_ADDR_WIDTH-1:0]   msg_addr,
  output logic [`CMP_STRB_WIDTH-1:0]        msg_mask,
  output logic [`CMP_DATA_WIDTH-1:0]        msg_wdata
);

  import core_mem_port_pkg::*;

  // Address bit that picks the half of the 64-bit word
  localparam int lane_bit = $clog2(`CMP_MSG_STRB_WIDTH);

  core_msg_t msg_r;

  always_ff @(posedge clk) begin
    msg_r <= msg_in;
    if (rst) begin
      msg_active <= 1'b0;
    end else begin
      msg_active <= msg_valid;
    end
  end

  assign msg_addr = msg_r.addr;

  always_comb begin
    if (msg_r.addr[lane_bit]) begin
      msg_mask  = {msg_r.strb, {`CMP_MSG_STRB_WIDTH{1'b0}}};
      msg_wdata = {msg_r.data, {`CMP_MSG_DATA_WIDTH{1'b0}}};
    end else begin
      msg_mask  = {{`CMP_MSG_STRB_WIDTH{1'b0}}, msg_r.strb};
      msg_wdata = {{`CMP_MSG_DATA_WIDTH{1'b0}}, msg_r.data};
    end
  end

endmodule

`default_nettype wire

/* verilog/dmem_access_mux.sv */
//////////////////////////////////////////////////////////////////////
// Data memory port steering. Purely combinational, the operation is
// chosen upstream.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "core_mem_port_defs.svh"

module dmem_access_mux (
  input  wire core_mem_port_pkg::wr_cmd_t  wr_cmd,
  input  wire core_mem_port_pkg::rd_cmd_t  rd_cmd,
  input  wire core_mem_port_pkg::dmem_op_e dmem_op,
  input  wire                              imem_sel,
  input  wire                              msg_active,
  input  wire [`CMP_DMEM_ADDR_WIDTH-1:0]   msg_addr,
  input  wire [`CMP_STRB_WIDTH-1:0]        msg_mask,
  input  wire [`CMP_DATA_WIDTH-1:0]        msg_wdata,
  output core_mem_port_pkg::dmem_req_t     dmem_req,
  output core_mem_port_pkg::imem_wr_t      imem_wr
);

  import core_mem_port_pkg::*;

  localparam int addr_pad = `CMP_ADDR_WIDTH - `CMP_DMEM_ADDR_WIDTH;

  always_comb begin
    dmem_req.en  = msg_active || (dmem_op != DMEM_IDLE);
    dmem_req.ren = !msg_active && (dmem_op == DMEM_READ);
    if (msg_active) begin
      dmem_req.addr  = {{addr_pad{1'b0}}, msg_addr};
      dmem_req.wen   = msg_mask;
      dmem_req.wdata = msg_wdata;
    end else if (dmem_op == DMEM_WRITE) begin
      dmem_req.addr  = {1'b0, wr_cmd.addr[`CMP_ADDR_WIDTH-2:0]};
      dmem_req.wen   = wr_cmd.strb;
      dmem_req.wdata = wr_cmd.data;
    end else begin
      // Read or idle, nothing gets written
      dmem_req.addr  = {1'b0, rd_cmd.addr[`CMP_ADDR_WIDTH-2:0]};
      dmem_req.wen   = '0;
      dmem_req.wdata = wr_cmd.data;
    end
  end

  // Instruction memory write port, strobes only for top-bit writes
  always_comb begin
    imem_wr.wen  = wr_cmd.strb & {`CMP_STRB_WIDTH{imem_sel}};
    imem_wr.addr = {1'b0, wr_cmd.addr[`CMP_ADDR_WIDTH-2:0]};
    imem_wr.data = wr_cmd.data;
  end

endmodule

`default_nettype wire

/* verilog/dmem_ram.sv */
//////////////////////////////////////////////////////////////////////
// Byte-write data memory, one-cycle read. Upper request address bits
// beyond the memory size are ignored.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "core_mem_port_defs.svh"

module dmem_ram (
  input  wire                               clk,
  input  wire core_mem_port_pkg::dmem_req_t dmem_req,
  output logic [`CMP_DATA_WIDTH-1:0]        rd_data
);

  localparam int word_count = `CMP_DMEM_SIZE_BYTES / `CMP_STRB_WIDTH;
  localparam int word_lsb   = $clog2(`CMP_STRB_WIDTH);
  localparam int byte_width = `CMP_DATA_WIDTH / `CMP_STRB_WIDTH;

  logic [`CMP_DATA_WIDTH-1:0]               mem [word_count];
  logic [`CMP_DMEM_ADDR_WIDTH-word_lsb-1:0] word_addr;

  assign word_addr = dmem_req.addr[`CMP_DMEM_ADDR_WIDTH-1:word_lsb];

  always_ff @(posedge clk) begin
    if (dmem_req.en) begin
      for (int i = 0; i < `CMP_STRB_WIDTH; i++) begin
        if (dmem_req.wen[i]) begin
          mem[word_addr][i*byte_width +: byte_width] <=
            dmem_req.wdata[i*byte_width +: byte_width];
        end
      end
      // Holds its value when not read
      if (dmem_req.ren) begin
        rd_data <= mem[word_addr];
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/core_mem_port.sv */
//////////////////////////////////////////////////////////////////////
// Memory-port block of the core wrapper. Commands use en/ready strobes,
// core messages are single-cycle pulses without back-pressure.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "core_mem_port_defs.svh"

module core_mem_port #(
  parameter int interleave = 1
) (
  input  wire                               clk,
  input  wire                               rst,
  // Control words
  input  wire [`CMP_DATA_WIDTH-1:0]         ctrl_data,
  input  wire                               ctrl_valid,
  // DMA commands
  input  wire core_mem_port_pkg::wr_cmd_t   wr_cmd,
  output logic                              wr_ready,
  input  wire core_mem_port_pkg::rd_cmd_t   rd_cmd,
  output logic                              rd_ready,
  // Read response
  output logic [`CMP_DATA_WIDTH-1:0]        rd_resp_data,
  output logic                              rd_resp_valid,
  input  wire                               rd_resp_ready,
  // Incoming core messages
  input  wire core_mem_port_pkg::core_msg_t msg_in,
  input  wire                               msg_valid,
  // Core side
  output core_mem_port_pkg::imem_wr_t       imem_wr,
  output logic                              core_reset
);

  import core_mem_port_pkg::*;

  logic                            msg_active;
  logic [`CMP_DMEM_ADDR_WIDTH-1:0] msg_addr;
  logic [`CMP_STRB_WIDTH-1:0]      msg_mask;
  logic [`CMP_DATA_WIDTH-1:0]      msg_wdata;
  dmem_op_e                        dmem_op;
  logic                            imem_sel;
  dmem_req_t                       dmem_req;

  port_control #(
    .interleave(interleave)
  ) i_port_control (
    .clk          (clk),
    .rst          (rst),
    .ctrl_data    (ctrl_data),
    .ctrl_valid   (ctrl_valid),
    .wr_cmd       (wr_cmd),
    .rd_cmd       (rd_cmd),
    .msg_active   (msg_active),
    .rd_resp_ready(rd_resp_ready),
    .wr_ready     (wr_ready),
    .rd_ready     (rd_ready),
    .rd_resp_valid(rd_resp_valid),
    .dmem_op      (dmem_op),
    .imem_sel     (imem_sel),
    .core_reset   (core_reset)
  );

  core_msg_stage i_core_msg_stage (
    .clk       (clk),
    .rst       (rst),
    .msg_in    (msg_in),
    .msg_valid (msg_valid),
    .msg_active(msg_active),
    .msg_addr  (msg_addr),
    .msg_mask  (msg_mask),
    .msg_wdata (msg_wdata)
  );

  dmem_access_mux i_dmem_access_mux (
    .wr_cmd    (wr_cmd),
    .rd_cmd    (rd_cmd),
    .dmem_op   (dmem_op),
    .imem_sel  (imem_sel),
    .msg_active(msg_active),
    .msg_addr  (msg_addr),
    .msg_mask  (msg_mask),
    .msg_wdata (msg_wdata),
    .dmem_req  (dmem_req),
    .imem_wr   (imem_wr)
  );

  // Response data comes straight from the RAM output register
  dmem_ram i_dmem_ram (
    .clk     (clk),
    .dmem_req(dmem_req),
    .rd_data (rd_resp_data)
  );

endmodule

`default_nettype wire

/* verification/core_mem_port_tb.sv */
//////////////////////////////////////////////////////////////////////
// Runs the DUT with interleave on. Only words first written in full
// are read back, since the RAM starts out unknown.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "core_mem_port_defs.svh"

module core_mem_port_tb;

  import core_mem_port_pkg::*;

  localparam int rand_words     = 16;
  localparam int rand_writes    = 32;
  localparam int mixed_cmds     = 12;
  // Cycles the tests take, plus slack for arbitration stalls
  localparam int planned_cycles = 40 + 2 * rand_words + rand_writes + 6 * mixed_cmds;
  localparam int margin_cycles  = 200;

  logic                       clk;
  logic                       rst;
  logic [`CMP_DATA_WIDTH-1:0] ctrl_data;
  logic                       ctrl_valid;
  wr_cmd_t                    wr_cmd;
  logic                       wr_ready;
  rd_cmd_t                    rd_cmd;
  logic                       rd_ready;
  logic [`CMP_DATA_WIDTH-1:0] rd_resp_data;
  logic                       rd_resp_valid;
  logic                       rd_resp_ready;
  core_msg_t                  msg_in;
  logic                       msg_valid;
  imem_wr_t                   imem_wr;
  logic                       core_reset;

  logic [31:0]                lcg_state;
  logic [`CMP_DATA_WIDTH-1:0] shadow [`CMP_DMEM_SIZE_BYTES / `CMP_STRB_WIDTH];
  int                         errors;

  core_mem_port #(.interleave(1)) i_dut (.*);

  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [63:0] random_word();
    logic [31:0] upper;
    upper = next_random();
    return {upper, next_random()};
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic report_protocol_error(input string what);
    errors++;
    $display("Protocol error at %0t: %s", $time, what);
  endtask

  // Byte-wise merge into the shadow copy
  task automatic update_shadow(input logic [`CMP_DMEM_ADDR_WIDTH-1:0] addr,
                               input logic [63:0] data, input logic [7:0] strb);
    for (int i = 0; i < `CMP_STRB_WIDTH; i++) begin
      if (strb[i]) begin
        shadow[addr[`CMP_DMEM_ADDR_WIDTH-1:3]][i*8 +: 8] = data[i*8 +: 8];
      end
    end
  endtask

  // Command stays up until the edge where it is taken
  task automatic dma_write(input logic [15:0] addr, input logic [63:0] data,
                           input logic [7:0] strb);
    logic taken;
    taken = 1'b0;
    wr_cmd = '{en: 1'b1, addr: addr, data: data, strb: strb, last: 1'b1};
    while (!taken) begin
      @(negedge clk);
      taken = wr_ready;
      @(posedge clk);
    end
    #1;
    wr_cmd.en = 1'b0;
    if (!addr[15]) begin
      update_shadow(addr[14:0], data, strb);
    end
  endtask

  // Response belongs in the cycle right after the grant
  task automatic dma_read(input logic [15:0] addr, input string name);
    logic taken;
    taken = 1'b0;
    rd_cmd = '{en: 1'b1, addr: addr, last: 1'b1};
    while (!taken) begin
      @(negedge clk);
      taken = rd_ready;
      @(posedge clk);
    end
    #1;
    rd_cmd.en = 1'b0;
    @(negedge clk);
    check_value({name, " valid"}, 64'd1, {63'd0, rd_resp_valid});
    check_value(name, shadow[addr[14:3]], rd_resp_data);
    @(posedge clk);
    #1;
  endtask

  // Address bit 2 picks the upper half of the word
  task automatic send_msg(input logic [14:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    msg_in = '{strb: strb, addr: addr, data: data};
    msg_valid = 1'b1;
    if (addr[2]) begin
      update_shadow(addr, {data, 32'h0}, {strb, 4'h0});
    end else begin
      update_shadow(addr, {32'h0, data}, {4'h0, strb});
    end
    @(posedge clk);
    #1;
    msg_valid = 1'b0;
  endtask

  task automatic send_ctrl(input logic [63:0] word);
    ctrl_data = word;
    ctrl_valid = 1'b1;
    @(posedge clk);
    #1;
    ctrl_valid = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks on every edge

  assert property (@(posedge clk) disable iff (rst)
    !(rd_ready && wr_ready && wr_cmd.en && !wr_cmd.addr[15]))
    else report_protocol_error("read and data memory write granted together");
  assert property (@(posedge clk) disable iff (rst) rd_ready |=> rd_resp_valid)
    else report_protocol_error("no read response after a read grant");
  assert property (@(posedge clk) disable iff (rst) (rd_resp_valid && !rd_resp_ready)
    |-> !rd_ready ##1 (rd_resp_valid && $stable(rd_resp_data)))
    else report_protocol_error("stalled response lost, changed or overtaken");
  assert property (@(posedge clk) disable iff (rst) msg_valid
    |=> !rd_ready && !(wr_ready && wr_cmd.en && !wr_cmd.addr[15]))
    else report_protocol_error("DMA command granted while a message held the port");
  assert property (@(posedge clk) disable iff (rst) (wr_cmd.en && wr_cmd.addr[15])
    |-> wr_ready && (imem_wr == {wr_cmd.strb, 1'b0, wr_cmd.addr[14:0], wr_cmd.data}))
    else report_protocol_error("instruction memory write missing or altered");
  assert property (@(posedge clk) disable iff (rst)
    !(wr_cmd.en && wr_cmd.addr[15]) |-> (imem_wr.wen == '0))
    else report_protocol_error("instruction memory strobes without a top-bit write");

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    logic [15:0] addr;
    logic [7:0]  strb;
    clk = 1'b0;
    rst = 1'b1;
    ctrl_data = '0;
    ctrl_valid = 1'b0;
    wr_cmd = '0;
    rd_cmd = '0;
    rd_resp_ready = 1'b1;
    msg_in = '0;
    msg_valid = 1'b0;
    lcg_state = 32'h42e3fbea;
    errors = 0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Core reset command
    check_value("reset_after_rst", 64'd1, {63'd0, core_reset});
    check_value("resp_idle_after_rst", 64'd0, {63'd0, rd_resp_valid});
    send_ctrl(64'h0000_1234_0000_0000);
    check_value("untagged_ctrl", 64'd1, {63'd0, core_reset});
    send_ctrl(64'hffff_0000_0000_0000);
    check_value("reset_cmd_low", 64'd0, {63'd0, core_reset});

    // Instruction memory writes leave data memory alone
    dma_write(16'h0100, random_word(), 8'hff);
    fork
      dma_write(16'h8100, 64'h0123_4567_89ab_cdef, 8'h5a);
      begin
        @(negedge clk);
        check_value("imem_wen", 64'h5a, {56'd0, imem_wr.wen});
        check_value("imem_addr", 64'h0100, {48'd0, imem_wr.addr});
        check_value("imem_data", 64'h0123_4567_89ab_cdef, imem_wr.data);
      end
    join
    dma_read(16'h0100, "imem_no_alias");

    // Random strobed writes over full words, then read back
    for (int i = 0; i < rand_words; i++) begin
      dma_write(16'h0200 + 16'(i * 8), random_word(), 8'hff);
    end
    for (int i = 0; i < rand_writes; i++) begin
      addr = 16'h0200 + 16'((next_random() % rand_words) * 8);
      strb = 8'(next_random() >> 24);
      dma_write(addr, random_word(), strb);
    end
    for (int i = 0; i < rand_words; i++) begin
      dma_read(16'h0200 + 16'(i * 8), "rand_readback");
    end

    // Stalled response with a second read waiting behind it
    rd_resp_ready = 1'b0;
    dma_read(16'h0208, "stall_first");
    rd_cmd = '{en: 1'b1, addr: 16'h0210, last: 1'b1};
    repeat (4) begin
      @(negedge clk);
      check_value("stall_valid", 64'd1, {63'd0, rd_resp_valid});
      check_value("stall_data", shadow[16'h0208 >> 3], rd_resp_data);
      check_value("stall_no_grant", 64'd0, {63'd0, rd_ready});
    end
    @(posedge clk);
    #1;
    rd_cmd.en = 1'b0;
    rd_resp_ready = 1'b1;
    dma_read(16'h0210, "after_stall");

    // Messages on both halves, then a write and a read that have to wait
    dma_write(16'h0600, random_word(), 8'hff);
    send_msg(15'h0604, next_random(), 4'hf);
    send_msg(15'h0600, next_random(), 4'b0110);
    fork
      dma_write(16'h0608, random_word(), 8'hff);
      dma_read(16'h0100, "read_after_msg");
      begin
        @(negedge clk);
        check_value("msg_blocks_write", 64'd0, {63'd0, wr_ready});
        check_value("msg_blocks_read", 64'd0, {63'd0, rd_ready});
      end
    join
    dma_read(16'h0600, "msg_readback");
    dma_read(16'h0608, "late_write");

    // Reads and writes competing for the port
    fork
      for (int i = 0; i < mixed_cmds; i++) begin
        dma_write(16'h0400 + 16'(i * 8), random_word(), 8'hff);
      end
      for (int i = 0; i < mixed_cmds; i++) begin
        dma_read(16'h0200 + 16'(i * 8), "mixed_read");
      end
    join
    for (int i = 0; i < mixed_cmds; i++) begin
      dma_read(16'h0400 + 16'(i * 8), "mixed_readback");
    end

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (planned_cycles + margin_cycles) @(posedge clk);
    $display("Timeout: commands were not accepted within %0d cycles",
             planned_cycles + margin_cycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* core_mem_port.f */
+incdir+verilog
verilog/core_mem_port_pkg.sv
verilog/port_control.sv
verilog/core_msg_stage.sv
verilog/dmem_access_mux.sv
verilog/dmem_ram.sv
verilog/core_mem_port.sv
verification/core_mem_port_tb.sv

/* Bender.yml */
package:
  name: core_mem_port

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/core_mem_port_pkg.sv
      - verilog/port_control.sv
      - verilog/core_msg_stage.sv
      - verilog/dmem_access_mux.sv
      - verilog/dmem_ram.sv
      - verilog/core_mem_port.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/core_mem_port_tb.sv
